/* design/item_ram.sv */
// read-first on a write to the same address, contents undefined until loaded
`timescale 1ns/100ps

module item_ram (
    input  logic                                clock,
    input  logic                                we,
    input  logic [miner_pkg::item_addr_w-1:0]   addr,
    input  logic [miner_pkg::item_word_w-1:0]   wdata,
    output logic [miner_pkg::item_word_w-1:0]   q
);
    import miner_pkg::*;

    logic [item_word_w-1:0] mem [item_count_max];

    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];
    end

endmodule

/* design/miner_config_regs.sv */
// item counts above 16 are clamped to 16, unused addresses are ignored
`timescale 1ns/100ps

module miner_config_regs (
    input  logic                                clock,
    input  logic                                resetn,
    input  logic                                cfg_we,
    input  logic [miner_pkg::cfg_addr_w-1:0]    cfg_addr,
    input  logic [31:0]                         cfg_wdata,
    output logic [miner_pkg::frame_w-1:0]       frame_period,
    output logic [miner_pkg::count_w-1:0]       item_count,
    output logic [miner_pkg::value_w-1:0]       value_stone,
    output logic [miner_pkg::value_w-1:0]       value_gold,
    output logic [miner_pkg::value_w-1:0]       value_gem
);
    import miner_pkg::*;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            frame_period <= frame_reset;
            item_count <= '0;
            value_stone <= stone_reset;
            value_gold <= gold_reset;
            value_gem <= gem_reset;
        end else if (cfg_we) begin
            case (cfg_addr)
                cfg_addr_frame: frame_period <= cfg_wdata[frame_w-1:0];
                cfg_addr_count: begin
                    if (cfg_wdata > item_count_max)
                        item_count <= item_count_max;
                    else
                        item_count <= cfg_wdata[count_w-1:0];
                end
                // stone in the low byte, then gold, then gem
                cfg_addr_value: begin
                    value_stone <= cfg_wdata[0 +: value_w];
                    value_gold <= cfg_wdata[value_w +: value_w];
                    value_gem <= cfg_wdata[2*value_w +: value_w];
                end
                default: ;
            endcase
        end
    end

endmodule

/* design/miner_pkg.sv */
// game constants sized for a 320x240 playfield, item words hold 9-bit x and 8-bit y only
package miner_pkg;

    localparam int coord_w = 10;
    localparam int frac_w = 8;
    localparam int item_addr_w = 4;
    localparam int count_w = item_addr_w + 1;
    localparam int item_word_w = 32;
    localparam int frame_w = 16;
    localparam int value_w = 8;
    localparam int score_w = 10;
    localparam int mag_w = 9;
    localparam int cfg_addr_w = 2;
    localparam int hold_w = 2;
    localparam int st_w = 4;

    localparam logic [count_w-1:0] item_count_max = 5'd16;

    // rope geometry, all in pixels or degrees
    localparam logic [coord_w-1:0] origin_x = 10'd160;
    localparam logic [coord_w-1:0] origin_y = 10'd45;
    localparam logic [coord_w-1:0] rope_min = 10'd20;
    localparam logic [coord_w-1:0] rope_max = 10'd275;
    localparam logic [coord_w-1:0] delta_len = 10'd6;
    localparam logic [coord_w-1:0] deg_start = 10'd165;
    localparam logic [coord_w-1:0] deg_low = 10'd15;
    localparam logic [coord_w-1:0] deg_high = 10'd165;

    // item word layout
    localparam int field_x_lsb = 23;
    localparam int field_x_w = 9;
    localparam int field_y_lsb = 11;
    localparam int field_y_w = 8;
    localparam int field_type_lsb = 2;
    localparam int field_type_w = 2;
    localparam int field_vis_bit = 1;
    localparam int field_mov_bit = 0;

    localparam logic [coord_w-1:0] item_w = 10'd22;
    localparam logic [coord_w-1:0] item_h = 10'd6;
    localparam logic [coord_w-1:0] bound_left = 10'd10;
    localparam logic [coord_w-1:0] bound_right = 10'd310;
    localparam logic [coord_w-1:0] bound_bottom = 10'd230;

    localparam logic [cfg_addr_w-1:0] cfg_addr_frame = 2'd0;
    localparam logic [cfg_addr_w-1:0] cfg_addr_count = 2'd1;
    localparam logic [cfg_addr_w-1:0] cfg_addr_value = 2'd2;

    localparam logic [hold_w-1:0] up_hold_frames = 2'd3;

    // register defaults after reset
    localparam logic [frame_w-1:0] frame_reset = 16'd4;
    localparam logic [value_w-1:0] stone_reset = 8'd1;
    localparam logic [value_w-1:0] gold_reset = 8'd2;
    localparam logic [value_w-1:0] gem_reset = 8'd5;

    // rope controller states
    localparam logic [st_w-1:0] st_stop = 4'd0;
    localparam logic [st_w-1:0] st_swing_ccw = 4'd1;
    localparam logic [st_w-1:0] st_swing_cw = 4'd2;
    localparam logic [st_w-1:0] st_step_down = 4'd3;
    localparam logic [st_w-1:0] st_scan_read = 4'd4;
    localparam logic [st_w-1:0] st_scan_cmp = 4'd5;
    localparam logic [st_w-1:0] st_mark_moving = 4'd6;
    localparam logic [st_w-1:0] st_step_up = 4'd7;
    localparam logic [st_w-1:0] st_drag_write = 4'd8;
    localparam logic [st_w-1:0] st_award = 4'd9;

endpackage

/* design/miner_top.sv */
// load writes are ignored while enable is high, a write cycle takes the port from the draw side
`timescale 1ns/100ps

module miner_top (
    input  logic                                clock,
    input  logic                                resetn,
    input  logic                                cfg_we,
    input  logic [miner_pkg::cfg_addr_w-1:0]    cfg_addr,
    input  logic [31:0]                         cfg_wdata,
    input  logic                                load_we,
    input  logic [miner_pkg::item_addr_w-1:0]   load_addr,
    input  logic [miner_pkg::item_word_w-1:0]   load_data,
    input  logic                                draw_busy,
    input  logic [miner_pkg::item_addr_w-1:0]   draw_addr,
    output logic [miner_pkg::item_word_w-1:0]   item_q,
    input  logic                                enable,
    input  logic                                go_key,
    output logic [miner_pkg::coord_w-1:0]       degree,
    output logic [miner_pkg::coord_w-1:0]       rope_len,
    output logic [miner_pkg::coord_w-1:0]       end_x,
    output logic [miner_pkg::coord_w-1:0]       end_y,
    output logic [miner_pkg::score_w-1:0]       score
);
    import miner_pkg::*;

    logic [frame_w-1:0] frame_period;
    logic [count_w-1:0] item_count;
    logic [value_w-1:0] value_stone;
    logic [value_w-1:0] value_gold;
    logic [value_w-1:0] value_gem;
    logic [mag_w-1:0] sin_mag;
    logic [mag_w-1:0] cos_mag;
    logic cos_neg;
    logic [item_addr_w-1:0] rope_addr;
    logic rope_we;
    logic [item_word_w-1:0] rope_wdata;
    logic score_en;
    logic [value_w-1:0] score_delta;
    logic ram_we;
    logic [item_addr_w-1:0] ram_addr;
    logic [item_word_w-1:0] ram_wdata;

    // host loads only while play is off
    assign ram_we = enable ? rope_we : load_we;
    assign ram_wdata = enable ? rope_wdata : load_data;
    always_comb begin
        if (ram_we)
            ram_addr = enable ? rope_addr : load_addr;
        else
            ram_addr = draw_busy ? draw_addr : rope_addr;
    end

    miner_config_regs i_config (
        .clock(clock), .resetn(resetn), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .frame_period(frame_period), .item_count(item_count),
        .value_stone(value_stone), .value_gold(value_gold), .value_gem(value_gem)
    );

    rope_controller i_rope (
        .clock(clock), .resetn(resetn), .enable(enable), .go_key(go_key),
        .draw_busy(draw_busy), .frame_period(frame_period), .item_count(item_count),
        .value_stone(value_stone), .value_gold(value_gold), .value_gem(value_gem),
        .sin_mag(sin_mag), .cos_mag(cos_mag), .cos_neg(cos_neg), .rope_q(item_q),
        .degree(degree), .rope_len(rope_len), .end_x(end_x), .end_y(end_y),
        .rope_addr(rope_addr), .rope_we(rope_we), .rope_wdata(rope_wdata),
        .score_en(score_en), .score_delta(score_delta)
    );

    trig_table i_trig (
        .degree(degree), .sin_mag(sin_mag), .cos_mag(cos_mag), .cos_neg(cos_neg)
    );

    item_ram i_ram (
        .clock(clock), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .q(item_q)
    );

    score_keeper i_score (
        .clock(clock), .resetn(resetn), .score_en(score_en),
        .score_delta(score_delta), .score(score)
    );

endmodule

/* design/rope_controller.sv */
// go_key must be clean, item x above 511 or y above 255 cannot be caught
`timescale 1ns/100ps

module rope_controller (
    input  logic                                clock,
    input  logic                                resetn,
    input  logic                                enable,
    input  logic                                go_key,
    input  logic                                draw_busy,
    input  logic [miner_pkg::frame_w-1:0]       frame_period,
    input  logic [miner_pkg::count_w-1:0]       item_count,
    input  logic [miner_pkg::value_w-1:0]       value_stone,
    input  logic [miner_pkg::value_w-1:0]       value_gold,
    input  logic [miner_pkg::value_w-1:0]       value_gem,
    input  logic [miner_pkg::mag_w-1:0]         sin_mag,
    input  logic [miner_pkg::mag_w-1:0]         cos_mag,
    input  logic                                cos_neg,
    input  logic [miner_pkg::item_word_w-1:0]   rope_q,
    output logic [miner_pkg::coord_w-1:0]       degree,
    output logic [miner_pkg::coord_w-1:0]       rope_len,
    output logic [miner_pkg::coord_w-1:0]       end_x,
    output logic [miner_pkg::coord_w-1:0]       end_y,
    output logic [miner_pkg::item_addr_w-1:0]   rope_addr,
    output logic                                rope_we,
    output logic [miner_pkg::item_word_w-1:0]   rope_wdata,
    output logic                                score_en,
    output logic [miner_pkg::value_w-1:0]       score_delta
);
    import miner_pkg::*;

    logic [st_w-1:0] state;
    logic [coord_w+frac_w-1:0] len_fx;
    logic [frame_w-1:0] frame_cnt;
    logic [count_w-1:0] scan_idx;
    logic [hold_w-1:0] hold_cnt;
    logic go_prev;
    logic go_flag;
    logic swing_cw;
    logic caught;
    logic settled;
    logic [item_word_w-1:0] item_word;
    logic [item_word_w-1:0] drag_word;
    logic [coord_w+mag_w-1:0] dx_full;
    logic [coord_w+mag_w-1:0] dy_full;
    logic [coord_w-1:0] dx;
    logic [coord_w-1:0] dy;
    logic [field_x_w-1:0] item_x;
    logic [field_y_w-1:0] item_y;
    logic waiting;
    logic frame_done;
    logic tick;
    logic hit;
    logic at_edge;
    logic near_rest;

    assign rope_len = len_fx[frac_w +: coord_w];
    assign rope_addr = scan_idx[item_addr_w-1:0];

    // tip offset, trig magnitudes carry a factor of 256
    assign dx_full = rope_len * cos_mag;
    assign dy_full = rope_len * sin_mag;
    assign dx = dx_full[frac_w +: coord_w];
    assign dy = dy_full[frac_w +: coord_w];

    always_ff @(posedge clock) begin
        if (cos_neg)
            end_x <= (dx >= origin_x) ? '0 : origin_x - dx;
        else
            end_x <= origin_x + dx;
        end_y <= origin_y + dy;
    end

    assign waiting = state == st_swing_ccw || state == st_swing_cw
                  || state == st_step_down || state == st_step_up;
    assign frame_done = (frame_cnt + 1'b1) >= frame_period;
    assign tick = waiting && frame_done && !draw_busy;

    // hit box of a visible item that is not already hooked
    assign item_x = rope_q[field_x_lsb +: field_x_w];
    assign item_y = rope_q[field_y_lsb +: field_y_w];
    assign hit = rope_q[field_vis_bit] && !rope_q[field_mov_bit]
              && end_x >= item_x && end_x <= item_x + item_w
              && end_y + item_h >= item_y && end_y <= item_y + item_w;

    assign at_edge = end_x <= bound_left || end_x >= bound_right
                  || end_y >= bound_bottom || rope_len >= rope_max;
    assign near_rest = rope_len <= rope_min + delta_len;

    // caught item follows the tip
    always_comb begin
        drag_word = item_word;
        drag_word[field_x_lsb +: field_x_w] = end_x[field_x_w-1:0];
        drag_word[field_y_lsb +: field_y_w] = end_y[field_y_w-1:0];
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_stop;
            len_fx <= {rope_min, {frac_w{1'b0}}};
            degree <= deg_start;
            frame_cnt <= '0;
            scan_idx <= '0;
            hold_cnt <= '0;
            go_prev <= 1'b0;
            go_flag <= 1'b0;
            swing_cw <= 1'b0;
            caught <= 1'b0;
            settled <= 1'b0;
            rope_we <= 1'b0;
            score_en <= 1'b0;
        end else begin
            rope_we <= 1'b0;
            score_en <= 1'b0;
            go_prev <= go_key;
            if (!waiting || tick)
                frame_cnt <= '0;
            else if (!frame_done)
                frame_cnt <= frame_cnt + 1'b1;
            if (go_key && !go_prev && (state == st_swing_ccw || state == st_swing_cw))
                go_flag <= 1'b1;

            if (!enable) begin
                state <= st_stop;
                len_fx <= {rope_min, {frac_w{1'b0}}};
                degree <= deg_start;
                go_flag <= 1'b0;
                caught <= 1'b0;
                settled <= 1'b0;
            end else begin
                case (state)
                    st_stop: begin
                        swing_cw <= 1'b0;
                        state <= st_swing_ccw;
                    end
                    st_swing_ccw, st_swing_cw: begin
                        if (tick && go_flag) begin
                            go_flag <= 1'b0;
                            state <= st_step_down;
                        end else if (tick && swing_cw) begin
                            degree <= degree + 1'b1;
                            if (degree + 1'b1 >= deg_high) begin
                                swing_cw <= 1'b0;
                                state <= st_swing_ccw;
                            end
                        end else if (tick) begin
                            degree <= degree - 1'b1;
                            if (degree - 1'b1 <= deg_low) begin
                                swing_cw <= 1'b1;
                                state <= st_swing_cw;
                            end
                        end
                    end
                    st_step_down: begin
                        if (tick) begin
                            len_fx <= len_fx + {delta_len, {frac_w{1'b0}}};
                            scan_idx <= '0;
                            state <= st_scan_read;
                        end
                    end
                    // address goes out here, data is compared next cycle
                    st_scan_read: begin
                        if (scan_idx >= item_count) begin
                            hold_cnt <= '0;
                            state <= at_edge ? st_step_up : st_step_down;
                        end else if (!draw_busy) begin
                            state <= st_scan_cmp;
                        end
                    end
                    st_scan_cmp: begin
                        if (hit) begin
                            item_word <= rope_q;
                            item_word[field_mov_bit] <= 1'b1;
                            caught <= 1'b1;
                            state <= st_mark_moving;
                        end else begin
                            scan_idx <= scan_idx + 1'b1;
                            state <= st_scan_read;
                        end
                    end
                    st_mark_moving: begin
                        rope_we <= 1'b1;
                        rope_wdata <= item_word;
                        hold_cnt <= up_hold_frames;
                        state <= st_step_up;
                    end
                    st_step_up: begin
                        if (tick && hold_cnt != '0) begin
                            hold_cnt <= hold_cnt - 1'b1;
                        end else if (tick) begin
                            if (near_rest)
                                len_fx <= {rope_min, {frac_w{1'b0}}};
                            else
                                len_fx <= len_fx - {delta_len, {frac_w{1'b0}}};
                            if (caught)
                                state <= st_drag_write;
                            else if (near_rest)
                                state <= swing_cw ? st_swing_cw : st_swing_ccw;
                        end
                    end
                    // one cycle for end_x and end_y to follow the new length
                    st_drag_write: begin
                        settled <= !settled;
                        if (settled) begin
                            rope_we <= 1'b1;
                            rope_wdata <= drag_word;
                            item_word <= drag_word;
                            hold_cnt <= up_hold_frames;
                            state <= (rope_len == rope_min) ? st_award : st_step_up;
                        end
                    end
                    st_award: begin
                        score_en <= 1'b1;
                        case (item_word[field_type_lsb +: field_type_w])
                            2'd0: score_delta <= value_stone;
                            2'd1: score_delta <= value_gold;
                            default: score_delta <= value_gem;
                        endcase
                        rope_we <= 1'b1;
                        rope_wdata <= item_word;
                        rope_wdata[field_vis_bit] <= 1'b0;
                        rope_wdata[field_mov_bit] <= 1'b0;
                        caught <= 1'b0;
                        state <= swing_cw ? st_swing_cw : st_swing_ccw;
                    end
                    default: state <= st_stop;
                endcase
            end
        end
    end

endmodule

/* design/score_keeper.sv */
// score holds at 1023 once reached, there is no way to subtract
`timescale 1ns/100ps

module score_keeper (
    input  logic                            clock,
    input  logic                            resetn,
    input  logic                            score_en,
    input  logic [miner_pkg::value_w-1:0]   score_delta,
    output logic [miner_pkg::score_w-1:0]   score
);
    import miner_pkg::*;

    // one extra bit catches the overflow
    logic [score_w:0] sum;

    assign sum = score + score_delta;

    always_ff @(posedge clock) begin
        if (!resetn)
            score <= '0;
        else if (score_en)
            score <= sum[score_w] ? '1 : sum[score_w-1:0];
    end

endmodule

/* design/trig_table.sv */
// magnitudes scaled by 256 in 8-degree bins, valid only for degree 0 to 180
`timescale 1ns/100ps

module trig_table (
    input  logic [miner_pkg::coord_w-1:0]   degree,
    output logic [miner_pkg::mag_w-1:0]     sin_mag,
    output logic [miner_pkg::mag_w-1:0]     cos_mag,
    output logic                            cos_neg
);
    import miner_pkg::*;

    logic [coord_w-1:0] folded;
    logic [coord_w-1:0] compl;

    // sine at the middle of each bin
    function automatic logic [mag_w-1:0] sin_bin(input logic [coord_w-1:0] angle);
        case (angle[coord_w-1:3])
            7'd0: sin_bin = 9'd18;
            7'd1: sin_bin = 9'd53;
            7'd2: sin_bin = 9'd88;
            7'd3: sin_bin = 9'd120;
            7'd4: sin_bin = 9'd150;
            7'd5: sin_bin = 9'd178;
            7'd6: sin_bin = 9'd202;
            7'd7: sin_bin = 9'd222;
            7'd8: sin_bin = 9'd237;
            7'd9: sin_bin = 9'd248;
            7'd10: sin_bin = 9'd255;
            default: sin_bin = 9'd256;
        endcase
    endfunction

    // mirror the upper quadrant onto 0 to 90
    assign folded = (degree > 10'd90) ? 10'd180 - degree : degree;
    assign compl = 10'd90 - folded;

    assign sin_mag = sin_bin(folded);
    assign cos_mag = sin_bin(compl);
    assign cos_neg = degree > 10'd90;

endmodule

/* sources.f */
design/miner_pkg.sv
design/miner_config_regs.sv
design/trig_table.sv
design/item_ram.sv
design/score_keeper.sv
design/rope_controller.sv
design/miner_top.sv
test/miner_checker.sv
test/miner_tb.sv

/* test/miner_checker.sv */
// samples on the rising edge, swing and rope checks run only while enable stays high
`timescale 1ns/100ps

module miner_checker (
    input  logic                                clock,
    input  logic                                resetn,
    input  logic                                enable,
    input  logic                                load_we,
    input  logic [miner_pkg::item_word_w-1:0]   load_data,
    input  logic                                draw_busy,
    input  logic [miner_pkg::item_word_w-1:0]   item_q,
    input  logic [miner_pkg::coord_w-1:0]       degree,
    input  logic [miner_pkg::coord_w-1:0]       rope_len,
    input  logic [miner_pkg::coord_w-1:0]       end_x,
    input  logic [miner_pkg::coord_w-1:0]       end_y,
    input  logic [miner_pkg::score_w-1:0]       score
);
    import miner_pkg::*;

    int error_count = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    string test_name = "reset";
    int exp_delta = 0;
    int exp_period = 0;
    int start_score = 0;
    int loaded_visible = 0;
    int read_visible = 0;
    logic read_pending = 1'b0;
    logic prev_enable = 1'b0;
    logic [coord_w-1:0] prev_degree = deg_start;
    logic [coord_w-1:0] prev_len = rope_min;
    int last_dir = 0;
    int step_cycles = 0;
    logic step_valid = 1'b0;
    logic falling = 1'b0;
    int diff;

    task automatic mismatch(input string what, input int expected, input int actual);
        $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                 test_name, what, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic fault(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_reset_state();
        test_name = "reset";
        test_errors = 0;
        if (score != '0)
            mismatch("score", 0, int'(score));
        if (rope_len != rope_min)
            mismatch("rope length", int'(rope_min), int'(rope_len));
        if (degree != deg_start)
            mismatch("degree", int'(deg_start), int'(degree));
        close_test();
    endtask

    task automatic start_test(input string name, input int delta, input int period);
        test_name = name;
        exp_delta = delta;
        exp_period = period;
        start_score = int'(score);
        loaded_visible = 0;
        read_visible = 0;
        test_errors = 0;
    endtask

    // one item caught per shot, so one visible bit less than was loaded
    task automatic finish_test();
        if (int'(score) - start_score != exp_delta)
            mismatch("score change", exp_delta, int'(score) - start_score);
        if (read_visible != loaded_visible - 1)
            mismatch("visible items", loaded_visible - 1, read_visible);
        close_test();
    endtask

    // tip from the rope geometry, the table bins are 8 degrees wide
    task automatic check_tip(input int len, input int deg);
        real rad;
        real exp_x;
        real exp_y;
        real tol;
        rad = deg * 3.14159265 / 180.0;
        exp_x = origin_x + len * $cos(rad);
        exp_y = origin_y + len * $sin(rad);
        if (exp_x < 0.0)
            exp_x = 0.0;
        // up to 4 degrees of bin error plus truncation
        tol = len / 14.0 + 2.0;
        if (end_x > exp_x + tol || end_x < exp_x - tol)
            mismatch("tip x", int'(exp_x), int'(end_x));
        if (end_y > exp_y + tol || end_y < exp_y - tol)
            mismatch("tip y", int'(exp_y), int'(end_y));
    endtask

    task automatic report();
        $display("%0d tests run, %0d tests failed, %0d check errors",
                 tests_run, tests_failed, error_count);
    endtask

    always @(posedge clock) begin
        // draw port data arrives one cycle after the address
        if (read_pending && item_q[field_vis_bit])
            read_visible++;
        read_pending = draw_busy;
        if (load_we && !enable && load_data[field_vis_bit])
            loaded_visible++;
        step_cycles++;
        if (!enable || draw_busy || rope_len != rope_min)
            step_valid = 1'b0;
        if (!enable) begin
            last_dir = 0;
            falling = 1'b0;
        end

        if (resetn) begin
            if (degree < deg_low || degree > deg_high)
                fault($sformatf("degree %0d is outside the swing range", degree));

            // tip registers lag degree and length by one cycle
            check_tip(int'(prev_len), int'(prev_degree));

            if (enable && prev_enable && degree != prev_degree) begin
                diff = int'(degree) - int'(prev_degree);
                if (diff != 1 && diff != -1)
                    mismatch("degree step", (diff > 0) ? 1 : -1, diff);
                if (last_dir != 0 && (diff > 0) != (last_dir > 0)
                        && prev_degree != deg_low && prev_degree != deg_high)
                    fault($sformatf("swing reversed at degree %0d", prev_degree));
                last_dir = (diff > 0) ? 1 : -1;
                if (step_valid && step_cycles != exp_period)
                    mismatch("frame spacing", exp_period, step_cycles);
                step_valid = 1'b1;
                step_cycles = 0;
            end

            if (enable && prev_enable && rope_len != prev_len) begin
                diff = int'(rope_len) - int'(prev_len);
                if (diff > 0) begin
                    if (falling)
                        fault("rope extended again before reaching rest");
                    if (diff != int'(delta_len))
                        mismatch("rope extend step", int'(delta_len), diff);
                end else begin
                    falling = 1'b1;
                    if (-diff != int'(delta_len))
                        mismatch("rope retract step", int'(delta_len), -diff);
                end
                if (rope_len == rope_min)
                    falling = 1'b0;
            end
        end

        prev_enable = enable;
        prev_degree = degree;
        prev_len = rope_len;
    end

endmodule

/* test/miner_tb.sv */
// go is pressed 70 to 80 swing steps after enable or after a full swing, so the rope drops near 90 degrees
`timescale 1ns/100ps

module miner_tb;
    import miner_pkg::*;

    localparam int n_tests = 4;
    localparam int base_frames = 70;

    logic clock = 1'b0;
    logic resetn;
    logic cfg_we;
    logic [cfg_addr_w-1:0] cfg_addr;
    logic [31:0] cfg_wdata;
    logic load_we;
    logic [item_addr_w-1:0] load_addr;
    logic [item_word_w-1:0] load_data;
    logic draw_busy;
    logic [item_addr_w-1:0] draw_addr;
    logic [item_word_w-1:0] item_q;
    logic enable;
    logic go_key;
    logic [coord_w-1:0] degree;
    logic [coord_w-1:0] rope_len;
    logic [coord_w-1:0] end_x;
    logic [coord_w-1:0] end_y;
    logic [score_w-1:0] score;

    // test table, one row per shot
    string test_name [n_tests];
    logic [1:0] item_type [n_tests];
    logic [7:0] new_stone [n_tests];
    logic [7:0] new_gold [n_tests];
    logic [7:0] new_gem [n_tests];
    int period [n_tests];
    // 300 extra steps swing out to both limits and back to the start
    int extra_steps [n_tests];
    int rand_frames [n_tests];
    int exp_delta [n_tests];
    int limit_cycles = 0;

    always #4 clock = ~clock;

    miner_top i_dut (
        .clock(clock), .resetn(resetn), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data), .draw_busy(draw_busy), .draw_addr(draw_addr),
        .item_q(item_q), .enable(enable), .go_key(go_key), .degree(degree),
        .rope_len(rope_len), .end_x(end_x), .end_y(end_y), .score(score)
    );

    miner_checker i_check (
        .clock(clock), .resetn(resetn), .enable(enable), .load_we(load_we),
        .load_data(load_data), .draw_busy(draw_busy), .item_q(item_q),
        .degree(degree), .rope_len(rope_len), .end_x(end_x), .end_y(end_y),
        .score(score)
    );

    task automatic add_entry(input int idx, input string name, input logic [1:0] kind,
                             input int stone, input int gold, input int gem,
                             input int frame, input int sweep, input int spread,
                             input int delta);
        test_name[idx] = name;
        item_type[idx] = kind;
        new_stone[idx] = stone[7:0];
        new_gold[idx] = gold[7:0];
        new_gem[idx] = gem[7:0];
        period[idx] = frame;
        extra_steps[idx] = sweep;
        rand_frames[idx] = spread;
        exp_delta[idx] = delta;
    endtask

    function automatic logic [item_word_w-1:0] make_item(input int x, input int y,
                                                         input logic [1:0] kind);
        logic [item_word_w-1:0] word;
        word = '0;
        word[field_x_lsb +: field_x_w] = x[field_x_w-1:0];
        word[field_y_lsb +: field_y_w] = y[field_y_w-1:0];
        word[field_type_lsb +: field_type_w] = kind;
        word[field_vis_bit] = 1'b1;
        return word;
    endfunction

    // sixteen items at y 200, 20 apart, so the box row has no gaps
    task automatic load_row(input logic [1:0] kind);
        int i;
        for (i = 0; i < 16; i++) begin
            @(posedge clock);
            load_we <= 1'b1;
            load_addr <= i[item_addr_w-1:0];
            load_data <= make_item(i * 20, 200, kind);
        end
        @(posedge clock);
        load_we <= 1'b0;
    endtask

    task automatic write_cfg(input logic [cfg_addr_w-1:0] addr, input logic [31:0] data);
        @(posedge clock);
        cfg_we <= 1'b1;
        cfg_addr <= addr;
        cfg_wdata <= data;
    endtask

    task automatic configure(input int frame, input logic [7:0] stone,
                             input logic [7:0] gold, input logic [7:0] gem);
        write_cfg(cfg_addr_frame, frame);
        write_cfg(cfg_addr_count, 32'd16);
        write_cfg(cfg_addr_value, {8'd0, gem, gold, stone});
        @(posedge clock);
        cfg_we <= 1'b0;
    endtask

    task automatic wait_swing_steps(input int n);
        logic [coord_w-1:0] last;
        int i;
        for (i = 0; i < n; i++) begin
            last = degree;
            @(posedge clock);
            while (degree == last)
                @(posedge clock);
        end
    endtask

    task automatic read_back();
        int a;
        for (a = 0; a < 16; a++) begin
            @(posedge clock);
            draw_busy <= 1'b1;
            draw_addr <= a[item_addr_w-1:0];
        end
        @(posedge clock);
        draw_busy <= 1'b0;
        // let the last word reach the checker
        repeat (2) @(posedge clock);
    endtask

    // shot budget is about 250 frames plus the scan cycles of every step down
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("timeout: the game never returned to rest within %0d cycles", limit_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int t;
        int frames;
        int max_period;
        int budget;
        int seed_value;
        resetn <= 1'b0;
        enable <= 1'b0;
        go_key <= 1'b0;
        cfg_we <= 1'b0;
        cfg_addr <= '0;
        cfg_wdata <= '0;
        load_we <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        draw_busy <= 1'b0;
        draw_addr <= '0;
        seed_value = $urandom(32'he4b2_6417);

        add_entry(0, "stone_default", 2'd0, 1, 2, 5, 4, 0, 10, 1);
        add_entry(1, "gold_default", 2'd1, 1, 2, 5, 3, 0, 6, 2);
        add_entry(2, "gem_rewritten", 2'd2, 3, 4, 9, 5, 0, 0, 9);
        add_entry(3, "gold_rewritten", 2'd1, 3, 7, 9, 2, 300, 10, 7);
        max_period = 0;
        for (t = 0; t < n_tests; t++)
            if (period[t] > max_period)
                max_period = period[t];
        budget = 0;
        for (t = 0; t < n_tests; t++)
            budget += (250 + extra_steps[t]) * max_period + 2000;
        limit_cycles = budget;

        repeat (8) @(posedge clock);
        resetn <= 1'b1;
        @(posedge clock);
        i_check.check_reset_state();

        for (t = 0; t < n_tests; t++) begin
            i_check.start_test(test_name[t], exp_delta[t], period[t]);
            load_row(item_type[t]);
            configure(period[t], new_stone[t], new_gold[t], new_gem[t]);
            @(posedge clock);
            enable <= 1'b1;
            frames = extra_steps[t] + base_frames + int'($urandom % (rand_frames[t] + 1));
            wait_swing_steps(frames);
            go_key <= 1'b1;
            @(posedge clock);
            go_key <= 1'b0;
            while (rope_len == rope_min)
                @(posedge clock);
            while (rope_len != rope_min)
                @(posedge clock);
            // swing resumes only after the award
            wait_swing_steps(1);
            enable <= 1'b0;
            read_back();
            i_check.finish_test();
        end

        i_check.report();
        if (i_check.error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
